//--- cpuDecode_defs.svh
/*
  Decode stage widths
  Word, register id and pipeline bundle sizes shared by the decode RTL
*/
`ifndef CPU_DECODE_DEFS_SVH
`define CPU_DECODE_DEFS_SVH
`default_nettype none

`define DATA_W    16  // Machine word
`define REG_ID_W  4   // 16 general registers
`define EX_SIG_W  63  // Execute bundle
`define MEM_SIG_W 18  // Memory bundle
`define WB_SIG_W  8   // Writeback bundle

`default_nettype wire
`endif

//--- decodePkg.sv
/*
  Decode package
  Opcode and branch condition encodings of the teaching CPU
*/
`default_nettype none

package decodePkg;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    opAdd    = 4'h0,
    opSub    = 4'h1,
    opXor    = 4'h2,
    opRed    = 4'h3,
    opSll    = 4'h4,
    opSra    = 4'h5,
    opRor    = 4'h6,
    opPaddsb = 4'h7,
    opLw     = 4'h8,
    opSw     = 4'h9,
    opLlb    = 4'hA,
    opLhb    = 4'hB,
    opB      = 4'hC,   // PC relative branch
    opBr     = 4'hD,   // Register branch
    opPcs    = 4'hE,
    opHlt    = 4'hF
  } opcodeT;

  // Branch condition in bits 11..9
  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGe, condLe, condOvf, condUncond
  } condT;

endpackage

`default_nettype wire

//--- decodeCtrlIf.sv
/*
  Decoded control word
  Carries the opcode decoder outputs to the operand builder and the
  branch resolver
*/
`timescale 1ns/100ps
`default_nettype none

interface decodeCtrlIf;

  logic       branch;               // b or br
  logic [3:0] aluOp;                // Opcode, add for lw/sw
  logic       aluSrc, regSrc;       // Immediate operand / rd as first source
  logic       zEn, nvEn;            // Flag update enables
  logic       memEnable, memWrite;  // Data memory access
  logic       regWrite, memToReg;   // Writeback control
  logic       hlt, pcs;

  // Opcode decoder side
  modport producer (output branch, aluOp, aluSrc, regSrc, zEn, nvEn,
                    memEnable, memWrite, regWrite, memToReg, hlt, pcs);

  // Datapath blocks read only
  modport consumer (input branch, aluOp, aluSrc, regSrc, zEn, nvEn,
                    memEnable, memWrite, regWrite, memToReg, hlt, pcs);

endinterface

`default_nettype wire

//--- controlUnit.sv
/*
  Opcode decoder
  Turns the top nibble of the instruction into the control word
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module controlUnit (
  input  wire logic [`DATA_W-1:0] instr,  // Fetched word
  decodeCtrlIf.producer           ctrl     // Decoded control out
);
  import decodePkg::*;

  opcodeT opcode;

  assign opcode = opcodeT'(instr[15:12]);

  always_comb begin
    // Everything off unless the opcode says otherwise
    ctrl.branch    = 1'b0;
    ctrl.aluOp     = opcode;
    ctrl.aluSrc    = 1'b0;
    ctrl.regSrc    = 1'b0;
    ctrl.zEn       = 1'b0;
    ctrl.nvEn      = 1'b0;
    ctrl.memEnable = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.hlt       = 1'b0;
    ctrl.pcs       = 1'b0;
    case (opcode)
      opAdd, opSub: begin
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1;  // Only arithmetic sets N and V
        ctrl.regWrite = 1'b1;
      end
      opXor: begin
        ctrl.zEn      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opRed, opPaddsb: ctrl.regWrite = 1'b1;  // No flag update
      opSll, opSra, opRor: begin              // Shift amount is imm4
        ctrl.zEn      = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opLw: begin
        ctrl.aluOp     = opAdd;  // Address = base + offset
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      opSw: begin
        ctrl.aluOp     = opAdd;
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      opLlb, opLhb: begin  // rd is also the source
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opB, opBr: ctrl.branch = 1'b1;
      opPcs: begin
        ctrl.pcs      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opHlt: ctrl.hlt = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- registerFile.sv
/*
  Register file
  16 x 16 bit, two combinational reads, one clocked write
  A same-cycle write is forwarded to the read ports
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module registerFile (
  input  wire logic                 clk,
  input  wire logic                 rstN,
  input  wire logic                 wrEn,     // Writeback valid
  input  wire logic [`REG_ID_W-1:0] wrId,
  input  wire logic [`DATA_W-1:0]   wrData,
  input  wire logic [`REG_ID_W-1:0] srcId1,
  input  wire logic [`REG_ID_W-1:0] srcId2,
  output logic      [`DATA_W-1:0]   srcData1,
  output logic      [`DATA_W-1:0]   srcData2
);

  localparam int regCnt = 1 << `REG_ID_W;

  logic [`DATA_W-1:0] regs [regCnt];

  // Storage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < regCnt; i++) regs[i] <= '0;  // All registers start at zero
    end else if (wrEn) begin
      regs[wrId] <= wrData;
    end
  end

  // Bypass beats the array on an id match
  assign srcData1 = (wrEn && (wrId == srcId1)) ? wrData : regs[srcId1];
  assign srcData2 = (wrEn && (wrId == srcId2)) ? wrData : regs[srcId2];

endmodule

`default_nettype wire

//--- branchResolver.sv
/*
  Branch resolver
  Checks the condition against Z/V/N, forms the relative or register
  target and decides predictor updates and PC redirect
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module branchResolver (
  input  wire logic [`DATA_W-1:0] instr,
  input  wire logic [2:0]         flags,            // Z, V, N
  input  wire logic [`DATA_W-1:0] srcData1,         // rs value for br
  input  wire logic [`DATA_W-1:0] pcCurr,           // PC fetched behind this branch
  input  wire logic [`DATA_W-1:0] pcNext,           // Fall-through address
  input  wire logic [`DATA_W-1:0] predictedTarget,  // From the BTB
  decodeCtrlIf.consumer           ctrl,
  output logic                    isBr,
  output logic                    actualTaken,
  output logic      [`DATA_W-1:0] branchTarget,
  output logic      [`DATA_W-1:0] actualTarget,
  output logic                    wenBht,
  output logic                    wenBtb,
  output logic                    updatePc
);
  import decodePkg::*;

  condT               cond;
  logic               zFlag, vFlag, nFlag;
  logic               condMet;
  logic [`DATA_W-1:0] relOffset;  // Word offset in bytes

  assign cond = condT'(instr[11:9]);
  assign {zFlag, vFlag, nFlag} = flags;
  assign isBr = instr[12];  // Low opcode bit splits b from br

  ////////////////////
  // Condition
  ////////////////////
  always_comb begin
    condMet = 1'b0;
    case (cond)
      condNe:     condMet = !zFlag;
      condEq:     condMet = zFlag;
      condGt:     condMet = !zFlag && !nFlag;
      condLt:     condMet = nFlag;
      condGe:     condMet = zFlag || (!zFlag && !nFlag);
      condLe:     condMet = nFlag || zFlag;
      condOvf:    condMet = vFlag;
      condUncond: condMet = 1'b1;
    endcase
  end

  ////////////////////
  // Targets
  ////////////////////
  assign relOffset    = {{(`DATA_W-10){instr[8]}}, instr[8:0], 1'b0};  // Sign-extend, x2
  assign branchTarget = isBr ? srcData1 : pcNext + relOffset;

  assign actualTaken  = ctrl.branch && condMet;
  assign actualTarget = actualTaken ? branchTarget : pcNext;

  // Predictor training and redirect
  assign wenBht   = ctrl.branch;
  assign wenBtb   = actualTaken && (predictedTarget != actualTarget);  // BTB entry stale
  assign updatePc = ctrl.branch && (pcCurr != actualTarget);          // Wrong path fetched

endmodule

`default_nettype wire

//--- operandBuilder.sv
/*
  Operand builder
  Picks source register ids, extends the immediate and packs the
  execute, memory and writeback bundles; a NOP squashes all three
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module operandBuilder (
  input  wire logic [`DATA_W-1:0]    instr,
  decodeCtrlIf.consumer              ctrl,
  input  wire logic [`DATA_W-1:0]    srcData1,
  input  wire logic [`DATA_W-1:0]    srcData2,
  output logic      [`REG_ID_W-1:0]  srcId1,
  output logic      [`REG_ID_W-1:0]  srcId2,
  output logic      [`EX_SIG_W-1:0]  exSignals,
  output logic      [`MEM_SIG_W-1:0] memSignals,
  output logic      [`WB_SIG_W-1:0]  wbSignals
);

  logic [`REG_ID_W-1:0] rd, rs, rt;
  logic [3:0]           imm4;
  logic [7:0]           imm8;    // llb/lhb byte
  logic [`DATA_W-1:0]   aluImm;
  logic                 isNop;

  ////////////////////
  // Field extraction
  ////////////////////
  assign rd    = instr[11:8];
  assign rs    = instr[7:4];
  assign rt    = instr[3:0];
  assign imm4  = instr[3:0];
  assign imm8  = instr[7:0];
  assign isNop = (instr == '0);

  assign srcId1 = ctrl.regSrc ? rd : rs;    // llb/lhb modify rd in place
  assign srcId2 = ctrl.memWrite ? rd : rt;  // sw stores rd

  // Memory offsets are signed, shift amounts are not
  assign aluImm = ctrl.regSrc    ? {{(`DATA_W-8){1'b0}}, imm8} :
                  ctrl.memEnable ? {{(`DATA_W-4){imm4[3]}}, imm4} :
                                   {{(`DATA_W-4){1'b0}}, imm4};

  ////////////////////
  // Bundles
  ////////////////////
  assign exSignals = isNop ? '0 :
                     {srcId1, srcId2, srcData1, aluImm, srcData2,
                      ctrl.aluOp, ctrl.aluSrc, ctrl.zEn, ctrl.nvEn};
  assign memSignals = isNop ? '0 : {srcData2, ctrl.memEnable, ctrl.memWrite};  // Store data
  assign wbSignals  = isNop ? '0 :
                      {rd, ctrl.regWrite, ctrl.memToReg, ctrl.hlt, ctrl.pcs};

endmodule

`default_nettype wire

//--- decodeStage.sv
/*
  Instruction decode stage
  Opcode decoder, register file, operand builder and branch resolver
  of the 16-bit pipelined CPU
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module decodeStage (
  input  wire logic                  clk,
  input  wire logic                  rstN,
  input  wire logic [`DATA_W-1:0]    pcCurr,
  input  wire logic [`DATA_W-1:0]    instr,
  input  wire logic [`DATA_W-1:0]    pcNext,
  input  wire logic [2:0]            flags,          // Z, V, N
  input  wire logic [`DATA_W-1:0]    predictedTarget,
  input  wire logic                  wbRegWrite,     // Writeback port
  input  wire logic [`REG_ID_W-1:0]  wbRegId,
  input  wire logic [`DATA_W-1:0]    wbData,
  output logic      [`EX_SIG_W-1:0]  exSignals,
  output logic      [`MEM_SIG_W-1:0] memSignals,
  output logic      [`WB_SIG_W-1:0]  wbSignals,
  output logic                       isBranch,
  output logic                       isBr,
  output logic                       actualTaken,
  output logic                       wenBht,
  output logic      [`DATA_W-1:0]    branchTarget,
  output logic                       wenBtb,
  output logic      [`DATA_W-1:0]    actualTarget,
  output logic                       updatePc
);

  logic [`REG_ID_W-1:0] srcId1, srcId2;
  logic [`DATA_W-1:0]   srcData1, srcData2;

  decodeCtrlIf ctrlBus ();

  controlUnit uCtrl (.instr, .ctrl(ctrlBus.producer));

  registerFile uRegFile (
    .clk, .rstN,
    .wrEn(wbRegWrite), .wrId(wbRegId), .wrData(wbData),  // From writeback stage
    .srcId1, .srcId2, .srcData1, .srcData2
  );

  operandBuilder uOperands (
    .instr, .ctrl(ctrlBus.consumer), .srcData1, .srcData2,
    .srcId1, .srcId2, .exSignals, .memSignals, .wbSignals
  );

  branchResolver uBranch (
    .instr, .flags, .srcData1, .pcCurr, .pcNext, .predictedTarget,
    .ctrl(ctrlBus.consumer), .isBr, .actualTaken, .branchTarget,
    .actualTarget, .wenBht, .wenBtb, .updatePc
  );

  assign isBranch = ctrlBus.branch;

endmodule

`default_nettype wire

//--- decodeStage_checker.sv
/*
  Decode stage assertions
  Branch and NOP properties of the top level, bound into decodeStage
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module decodeStage_checker (
  input wire logic                  clk,
  input wire logic                  rstN,
  input wire logic [`DATA_W-1:0]    instr,
  input wire logic [`EX_SIG_W-1:0]  exSignals,
  input wire logic [`MEM_SIG_W-1:0] memSignals,
  input wire logic [`WB_SIG_W-1:0]  wbSignals,
  input wire logic                  isBranch,
  input wire logic                  actualTaken,
  input wire logic                  wenBtb,
  input wire logic                  updatePc
);

  int failCount = 0;  // Assertion failures so far

  // BTB is only trained by a taken branch
  btbNeedsTaken: assert property (@(posedge clk) disable iff (!rstN) wenBtb |-> actualTaken)
    else begin
      failCount++;
      $error("wenBtb set without a taken branch");
    end

  takenNeedsBranch: assert property (@(posedge clk) disable iff (!rstN) actualTaken |-> isBranch)
    else begin
      failCount++;
      $error("actualTaken set for a non-branch instruction");
    end

  // Only a branch may redirect fetch
  redirectNeedsBranch: assert property (@(posedge clk) disable iff (!rstN) updatePc |-> isBranch)
    else begin
      failCount++;
      $error("updatePc set for a non-branch instruction");
    end

  nopSquash: assert property (@(posedge clk) disable iff (!rstN)
    (instr == '0) |-> (exSignals == '0 && memSignals == '0 && wbSignals == '0))
    else begin
      failCount++;
      $error("NOP left a bundle bit set");
    end

endmodule

bind decodeStage decodeStage_checker uCheck (
  .clk, .rstN, .instr, .exSignals, .memSignals, .wbSignals,
  .isBranch, .actualTaken, .wenBtb, .updatePc
);

`default_nettype wire

//--- decodeStage_monitor.sv
/*
  Decode stage monitor
  Shadow register file and reference model of the decode rules;
  compares every output at the falling edge and reports per test
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module decodeStage_monitor (
  input  wire logic                  clk,
  input  wire logic                  rstN,
  input  wire logic [`DATA_W-1:0]    pcCurr,
  input  wire logic [`DATA_W-1:0]    instr,
  input  wire logic [`DATA_W-1:0]    pcNext,
  input  wire logic [2:0]            flags,
  input  wire logic [`DATA_W-1:0]    predictedTarget,
  input  wire logic                  wbRegWrite,
  input  wire logic [`REG_ID_W-1:0]  wbRegId,
  input  wire logic [`DATA_W-1:0]    wbData,
  input  wire logic [`EX_SIG_W-1:0]  exSignals,
  input  wire logic [`MEM_SIG_W-1:0] memSignals,
  input  wire logic [`WB_SIG_W-1:0]  wbSignals,
  input  wire logic                  isBranch,
  input  wire logic                  isBr,
  input  wire logic                  actualTaken,
  input  wire logic                  wenBht,
  input  wire logic [`DATA_W-1:0]    branchTarget,
  input  wire logic                  wenBtb,
  input  wire logic [`DATA_W-1:0]    actualTarget,
  input  wire logic                  updatePc,
  input  int                         testNum,   // 0 while idle
  output int                         errCount
);
  import decodePkg::*;

  logic [`DATA_W-1:0] shadow [16];  // Mirror of the register file
  int lastTest, testChecks, testErrs, totalChecks, testsDone;

  // Writebacks land at the rising edge
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) shadow[i] <= '0;
    end else if (wbRegWrite) begin
      shadow[wbRegId] <= wbData;
    end
  end

  function automatic logic [`DATA_W-1:0] readReg(input logic [`REG_ID_W-1:0] id);
    return (wbRegWrite && wbRegId == id) ? wbData : shadow[id];  // Same-cycle forward
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
    testChecks++;
    totalChecks++;
    if (expVal !== actVal) begin
      errCount++;
      testErrs++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  task automatic compareAll();
    opcodeT                 op;
    logic [`REG_ID_W-1:0]   rd, id1, id2;
    logic [3:0]             aluOp;
    logic [`DATA_W-1:0]     d1, d2, imm, brTgt, actTgt;
    logic                   zEn, nvEn, aluSrc, regSrc, memEn, memWr, memToReg, regWr;
    logic                   branch, z, v, n, condOk, taken;
    logic [`EX_SIG_W-1:0]   expEx;
    logic [`MEM_SIG_W-1:0]  expMem;
    logic [`WB_SIG_W-1:0]   expWb;
    op       = opcodeT'(instr[15:12]);
    zEn      = op inside {opAdd, opSub, opXor, opSll, opSra, opRor};
    nvEn     = op inside {opAdd, opSub};
    aluSrc   = op inside {opSll, opSra, opRor, opLw, opSw, opLlb, opLhb};
    regSrc   = op inside {opLlb, opLhb};
    memEn    = op inside {opLw, opSw};
    memWr    = (op == opSw);
    memToReg = (op == opLw);
    regWr    = (instr[15:12] <= 4'h8) || (op inside {opLlb, opLhb, opPcs});
    branch   = op inside {opB, opBr};
    aluOp    = memEn ? 4'h0 : instr[15:12];  // Loads and stores add
    rd  = instr[11:8];
    id1 = regSrc ? rd : instr[7:4];
    id2 = memWr ? rd : instr[3:0];
    d1  = readReg(id1);
    d2  = readReg(id2);
    imm = regSrc ? {8'h00, instr[7:0]} :
          memEn  ? {{12{instr[3]}}, instr[3:0]} : {12'h000, instr[3:0]};
    expEx  = {id1, id2, d1, imm, d2, aluOp, aluSrc, zEn, nvEn};
    expMem = {d2, memEn, memWr};
    expWb  = {rd, regWr, memToReg, op == opHlt, op == opPcs};
    if (instr == '0) begin  // NOP
      expEx  = '0;
      expMem = '0;
      expWb  = '0;
    end
    {z, v, n} = flags;
    case (condT'(instr[11:9]))
      condNe:  condOk = !z;
      condEq:  condOk = z;
      condGt:  condOk = !z && !n;
      condLt:  condOk = n;
      condGe:  condOk = z || (!z && !n);
      condLe:  condOk = n || z;
      condOvf: condOk = v;
      default: condOk = 1'b1;
    endcase
    taken  = branch && condOk;
    brTgt  = instr[12] ? d1 : pcNext + {{6{instr[8]}}, instr[8:0], 1'b0};
    actTgt = taken ? brTgt : pcNext;
    checkValue("exSignals", 64'(expEx), 64'(exSignals));
    checkValue("memSignals", 64'(expMem), 64'(memSignals));
    checkValue("wbSignals", 64'(expWb), 64'(wbSignals));
    checkValue("isBranch", 64'(branch), 64'(isBranch));
    checkValue("isBr", 64'(instr[12]), 64'(isBr));
    checkValue("actualTaken", 64'(taken), 64'(actualTaken));
    checkValue("wenBht", 64'(branch), 64'(wenBht));
    checkValue("branchTarget", 64'(brTgt), 64'(branchTarget));
    checkValue("actualTarget", 64'(actTgt), 64'(actualTarget));
    checkValue("wenBtb", 64'(taken && (predictedTarget != actTgt)), 64'(wenBtb));
    checkValue("updatePc", 64'(branch && (pcCurr != actTgt)), 64'(updatePc));
  endtask

  // Outputs are settled half a cycle after the drive point
  always @(negedge clk) begin
    if (testNum != lastTest) begin
      if (lastTest != 0) begin
        testsDone++;
        $display("Test %0d finished: %0d checks, %0d mismatches",
                 lastTest, testChecks, testErrs);
        if (testNum == 0)
          $display("Summary: %0d tests, %0d checks, %0d mismatches",
                   testsDone, totalChecks, errCount);
      end
      lastTest   = testNum;
      testChecks = 0;
      testErrs   = 0;
    end
    if (rstN && testNum != 0) compareAll();
  end

endmodule

`default_nettype wire

//--- decodeStage_tb.sv
/*
  Decode stage testbench
  Clock, reset, seeded random stimulus for six tests and a watchdog
*/
`timescale 1ns/100ps
`include "cpuDecode_defs.svh"
`default_nettype none

module decodeStage_tb;
  import decodePkg::*;

  localparam int totalCycles = 16 + 64 + 32 + 64 + 256 + 2000;

  logic                  clk = 1'b0;
  logic                  rstN = 1'b0;
  logic [`DATA_W-1:0]    pcCurr, instr, pcNext, predictedTarget, wbData;
  logic [2:0]            flags;            // Z, V, N
  logic                  wbRegWrite;
  logic [`REG_ID_W-1:0]  wbRegId;
  logic [`EX_SIG_W-1:0]  exSignals;
  logic [`MEM_SIG_W-1:0] memSignals;
  logic [`WB_SIG_W-1:0]  wbSignals;
  logic                  isBranch, isBr, actualTaken, wenBht, wenBtb, updatePc;
  logic [`DATA_W-1:0]    branchTarget, actualTarget;
  int                    testNum;
  int                    errCount;
  opcodeT                immOps [7] = '{opLlb, opLhb, opLw, opSw, opSll, opSra, opRor};

  decodeStage UUT (.*);
  decodeStage_monitor uMonitor (.*);

  always #10 clk = ~clk;  // 20 ns period

  task automatic randomizeInputs();
    pcCurr          = 16'($urandom);
    pcNext          = 16'($urandom);
    predictedTarget = 16'($urandom);
    flags           = 3'($urandom);
    wbRegWrite      = 1'($urandom);
    wbRegId         = 4'($urandom);
    wbData          = 16'($urandom);
  endtask

  // Target itself, fall-through or noise
  function automatic logic [`DATA_W-1:0] pickAddr(input logic [`DATA_W-1:0] tgt);
    case ($urandom % 3)
      0:       return tgt;
      1:       return pcNext;
      default: return 16'($urandom);
    endcase
  endfunction

  task automatic runTest(input int id, input int cycles);
    logic [`DATA_W-1:0] tgt;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      #2;
      testNum = id;
      randomizeInputs();
      case (id)
        1: begin  // Fresh registers read back as zero
          wbRegWrite = 1'b0;
          instr = {4'h0, 4'h1, 4'(i), 4'(15 - i)};
        end
        2: begin  // Writebacks with reads, some of the register being written
          wbRegWrite = ($urandom % 4) != 0;
          instr = {4'h0, 4'($urandom), (i % 2 == 1) ? wbRegId : 4'($urandom),
                   (i % 3 == 0) ? wbRegId : 4'($urandom)};
        end
        3: instr = (i == cycles - 1) ? 16'h0000 : {4'(i), 12'($urandom)};
        4: instr = {immOps[3'($urandom % 7)], 12'($urandom)};
        5: begin  // Every b/br, condition and flag pattern
          instr = {3'b110, 1'(i >> 6), 3'(i), 9'($urandom)};
          flags = 3'(i >> 3);
          if (instr[12]) begin  // br target forwarded from writeback
            wbRegWrite = 1'b1;
            wbRegId    = instr[7:4];
            tgt        = wbData;
          end else begin
            tgt = pcNext + {{6{instr[8]}}, instr[8:0], 1'b0};
          end
          pcCurr          = pickAddr(tgt);
          predictedTarget = pickAddr(tgt);
        end
        default: begin
          instr = 16'($urandom);
          if ($urandom % 4 == 0) pcCurr = pcNext;
        end
      endcase
    end
  endtask

  initial begin
    void'($urandom(60991));
    randomizeInputs();
    instr      = '0;
    wbRegWrite = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rstN = 1'b1;
    runTest(1, 16);
    runTest(2, 64);
    runTest(3, 32);
    runTest(4, 64);
    runTest(5, 256);
    runTest(6, 2000);
    @(posedge clk);
    #2;
    testNum = 0;  // Monitor closes the last test
    @(negedge clk);
    #1;
    if (errCount == 0 && UUT.uCheck.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog at twice the expected run time
  initial begin
    #(2 * (totalCycles + 8) * 20);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpuDecode.f
+incdir+.
decodePkg.sv
decodeCtrlIf.sv
controlUnit.sv
registerFile.sv
branchResolver.sv
operandBuilder.sv
decodeStage.sv
decodeStage_checker.sv
decodeStage_monitor.sv
decodeStage_tb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cpuDecode.f --top-module decodeStage_tb -o simDecode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simDecode +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
